// ==== i3c_bus_pkg.sv ====
// Bus-side encodings for the I3C config subsystem, imported by configuration, timers and top
package i3c_bus_pkg;

  // Timer width
  // 20 bits covers 1 ms at a 1 GHz core clock
  localparam int unsigned timer_w = 20;

  // Standby controller mode from STBY_CR_CONTROL
  typedef enum logic [1:0] {
    mode_disabled     = 2'b00,
    mode_acm_init     = 2'b01,
    mode_scm_running  = 2'b10,
    mode_scm_hot_join = 2'b11
  } mode_t;

  // PHY multiplexer select
  // Bit 0 picks I3C over I2C, bit 1 picks standby over active
  typedef enum logic [1:0] {
    phy_i2c_active  = 2'b00,
    phy_i3c_active  = 2'b01,
    phy_i2c_standby = 2'b10,
    phy_i3c_standby = 2'b11
  } phy_sel_t;

endpackage

// ==== i3c_csr_pkg.sv ====
// CSR map of the I3C config block, shared by the register file and its consumers
package i3c_csr_pkg;

  // Port widths
  localparam int unsigned csr_addr_w = 8;
  localparam int unsigned csr_data_w = 32;

  // Register addresses
  localparam logic [csr_addr_w-1:0] addr_hc_control      = 8'h00;
  localparam logic [csr_addr_w-1:0] addr_pio_control     = 8'h04;
  localparam logic [csr_addr_w-1:0] addr_stby_cr_control = 8'h08;
  localparam logic [csr_addr_w-1:0] addr_t_r             = 8'h10;
  localparam logic [csr_addr_w-1:0] addr_t_hd_dat        = 8'h14;
  localparam logic [csr_addr_w-1:0] addr_t_free          = 8'h18;
  localparam logic [csr_addr_w-1:0] addr_t_idle          = 8'h1C;
  localparam logic [csr_addr_w-1:0] addr_t_aval          = 8'h20;

  // HC_CONTROL fields
  localparam int unsigned hc_bus_enable_bit      = 31;
  localparam int unsigned hc_resume_bit          = 30;
  localparam int unsigned hc_abort_bit           = 29;
  localparam int unsigned hc_i2c_dev_present_bit = 7;

  // PIO_CONTROL fields
  localparam int unsigned pio_enable_bit = 0;
  localparam int unsigned pio_rs_bit     = 1;
  localparam int unsigned pio_abort_bit  = 2;

  // STBY_CR_CONTROL fields
  localparam int unsigned stby_enable_init_lsb        = 0;
  localparam int unsigned stby_enable_init_w          = 2;
  localparam int unsigned stby_target_xact_enable_bit = 4;

  // Stored fields only, timing values kept at timer width
  typedef struct packed {
    logic                                hc_bus_enable;
    logic                                hc_resume;
    logic                                hc_abort;
    logic                                hc_i2c_dev_present;
    logic                                pio_enable;
    logic                                pio_rs;
    logic                                pio_abort;
    logic [stby_enable_init_w-1:0]       stby_enable_init;
    logic                                stby_target_xact_enable;
    logic [i3c_bus_pkg::timer_w-1:0]     t_r;
    logic [i3c_bus_pkg::timer_w-1:0]     t_hd_dat;
    logic [i3c_bus_pkg::timer_w-1:0]     t_free;
    logic [i3c_bus_pkg::timer_w-1:0]     t_idle;
    logic [i3c_bus_pkg::timer_w-1:0]     t_aval;
  } hwif_out_t;

endpackage

// ==== csr_bus_if.sv ====
// CSR strobe port between the top-level host pins and the register file
`timescale 1ns/10ps

interface csr_bus_if;
  import i3c_csr_pkg::*;

  // Request, one-cycle strobes, never both at once
  logic                  wr_stb;
  logic                  rd_stb;
  logic [csr_addr_w-1:0] addr;
  logic [csr_data_w-1:0] wdata;

  // Response, one cycle after rd_stb
  logic [csr_data_w-1:0] rdata;
  logic                  rd_valid;

  // Host side drives requests
  modport host (output wr_stb, rd_stb, addr, wdata, input rdata, rd_valid);

  // Register side answers
  modport regs (input wr_stb, rd_stb, addr, wdata, output rdata, rd_valid);

endinterface

// ==== i3c_csr_regs.sv ====
// Register file for the I3C config CSRs, strobed writes and registered one-cycle reads
`timescale 1ns/10ps

module i3c_csr_regs (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  csr_bus_if.regs                bus,
  output i3c_csr_pkg::hwif_out_t hwif_out_o
);
  import i3c_csr_pkg::*;
  import i3c_bus_pkg::*;

  hwif_out_t             regs_q;
  logic [csr_data_w-1:0] rd_word;

  // Write decode, unknown addresses dropped
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      regs_q <= '0;
    end else if (bus.wr_stb) begin
      case (bus.addr)
        addr_hc_control: begin
          regs_q.hc_bus_enable      <= bus.wdata[hc_bus_enable_bit];
          regs_q.hc_resume          <= bus.wdata[hc_resume_bit];
          regs_q.hc_abort           <= bus.wdata[hc_abort_bit];
          regs_q.hc_i2c_dev_present <= bus.wdata[hc_i2c_dev_present_bit];
        end
        addr_pio_control: begin
          regs_q.pio_enable <= bus.wdata[pio_enable_bit];
          regs_q.pio_rs     <= bus.wdata[pio_rs_bit];
          regs_q.pio_abort  <= bus.wdata[pio_abort_bit];
        end
        addr_stby_cr_control: begin
          regs_q.stby_enable_init <=
            bus.wdata[stby_enable_init_lsb +: stby_enable_init_w];
          regs_q.stby_target_xact_enable <= bus.wdata[stby_target_xact_enable_bit];
        end
        // Timing registers keep the low timer bits
        addr_t_r:      regs_q.t_r      <= bus.wdata[timer_w-1:0];
        addr_t_hd_dat: regs_q.t_hd_dat <= bus.wdata[timer_w-1:0];
        addr_t_free:   regs_q.t_free   <= bus.wdata[timer_w-1:0];
        addr_t_idle:   regs_q.t_idle   <= bus.wdata[timer_w-1:0];
        addr_t_aval:   regs_q.t_aval   <= bus.wdata[timer_w-1:0];
        default: ;
      endcase
    end
  end

  // Read mux, fields back at their bit positions
  always_comb begin
    rd_word = '0;
    case (bus.addr)
      addr_hc_control: begin
        rd_word[hc_bus_enable_bit]      = regs_q.hc_bus_enable;
        rd_word[hc_resume_bit]          = regs_q.hc_resume;
        rd_word[hc_abort_bit]           = regs_q.hc_abort;
        rd_word[hc_i2c_dev_present_bit] = regs_q.hc_i2c_dev_present;
      end
      addr_pio_control: begin
        rd_word[pio_enable_bit] = regs_q.pio_enable;
        rd_word[pio_rs_bit]     = regs_q.pio_rs;
        rd_word[pio_abort_bit]  = regs_q.pio_abort;
      end
      addr_stby_cr_control: begin
        rd_word[stby_enable_init_lsb +: stby_enable_init_w] = regs_q.stby_enable_init;
        rd_word[stby_target_xact_enable_bit] = regs_q.stby_target_xact_enable;
      end
      addr_t_r:      rd_word[timer_w-1:0] = regs_q.t_r;
      addr_t_hd_dat: rd_word[timer_w-1:0] = regs_q.t_hd_dat;
      addr_t_free:   rd_word[timer_w-1:0] = regs_q.t_free;
      addr_t_idle:   rd_word[timer_w-1:0] = regs_q.t_idle;
      addr_t_aval:   rd_word[timer_w-1:0] = regs_q.t_aval;
      default:       rd_word = '0;
    endcase
  end

  // Read valid strobe
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bus.rd_valid <= 1'b0;
    end else begin
      bus.rd_valid <= bus.rd_stb;
    end
  end

  // Read data captured with the strobe
  always_ff @(posedge clk_i) begin
    if (bus.rd_stb) begin
      bus.rdata <= rd_word;
    end
  end

  assign hwif_out_o = regs_q;

endmodule

// ==== configuration.sv ====
// Decodes the CSR struct into mode enables, PHY select and timing values for the bus side
`timescale 1ns/10ps

module configuration (
  input  i3c_csr_pkg::hwif_out_t          hwif_out_i,

  // PHY and mode enables
  output logic                            phy_en_o,
  output i3c_bus_pkg::phy_sel_t           phy_mux_select_o,
  output logic                            i2c_active_en_o,
  output logic                            i2c_standby_en_o,
  output logic                            i3c_active_en_o,
  output logic                            i3c_standby_en_o,

  // To bus monitor
  output logic [i3c_bus_pkg::timer_w-1:0] t_hd_dat_o,
  output logic [i3c_bus_pkg::timer_w-1:0] t_r_o,

  // To bus timers
  output logic [i3c_bus_pkg::timer_w-1:0] t_bus_free_o,
  output logic [i3c_bus_pkg::timer_w-1:0] t_bus_idle_o,
  output logic [i3c_bus_pkg::timer_w-1:0] t_bus_available_o
);
  import i3c_bus_pkg::*;

  mode_t stby_mode;

  // Standby controller mode
  assign stby_mode = mode_t'(hwif_out_i.stby_enable_init);

  // Active controller in ACM init and hot-join
  assign i3c_active_en_o  = (stby_mode == mode_acm_init) ||
                            (stby_mode == mode_scm_hot_join);
  assign i3c_standby_en_o = (stby_mode == mode_scm_running);

  // No I2C controller path yet
  assign i2c_active_en_o  = 1'b0;
  assign i2c_standby_en_o = 1'b0;

  // PHY follows bus enable
  assign phy_en_o = hwif_out_i.hc_bus_enable;

  // Bit 1 standby, bit 0 I3C
  assign phy_mux_select_o = phy_sel_t'({i2c_standby_en_o | i3c_standby_en_o,
                                        i3c_active_en_o | i3c_standby_en_o});

  // Resume, abort, PIO and target-xact fields go to engines outside this block

  // Timing values straight through
  assign t_hd_dat_o        = hwif_out_i.t_hd_dat;
  assign t_r_o             = hwif_out_i.t_r;
  assign t_bus_free_o      = hwif_out_i.t_free;
  assign t_bus_idle_o      = hwif_out_i.t_idle;
  assign t_bus_available_o = hwif_out_i.t_aval;

endmodule

// ==== bus_timers.sv ====
// Counts cycles with SCL and SDA high and flags bus free, idle and available
`timescale 1ns/10ps

module bus_timers (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            enable_i,
  input  logic                            scl_i,
  input  logic                            sda_i,

  // Thresholds in core clock cycles
  input  logic [i3c_bus_pkg::timer_w-1:0] t_free_i,
  input  logic [i3c_bus_pkg::timer_w-1:0] t_idle_i,
  input  logic [i3c_bus_pkg::timer_w-1:0] t_aval_i,

  output logic                            bus_free_o,
  output logic                            bus_idle_o,
  output logic                            bus_available_o
);
  import i3c_bus_pkg::*;

  logic               lines_high;
  logic [timer_w-1:0] cnt_q;

  // Both lines released and timers enabled
  assign lines_high = enable_i & scl_i & sda_i;

  // Saturating high-time counter
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else if (!lines_high) begin
      cnt_q <= '0;
    end else if (cnt_q != '1) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Flags lag the count by one cycle
  // Any low line clears them at the same edge as the count
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      bus_free_o      <= 1'b0;
      bus_idle_o      <= 1'b0;
      bus_available_o <= 1'b0;
    end else begin
      bus_free_o      <= lines_high && (cnt_q >= t_free_i);
      bus_idle_o      <= lines_high && (cnt_q >= t_idle_i);
      bus_available_o <= lines_high && (cnt_q >= t_aval_i);
    end
  end

endmodule

// ==== i3c_cfg_top.sv ====
// Top level of the I3C config subsystem, CSR port in, mode enables, timings and bus flags out
`timescale 1ns/10ps

module i3c_cfg_top (
  input  logic                                clk_i,
  input  logic                                arst_n_i,

  // CSR host port
  input  logic                                csr_wr_stb_i,
  input  logic                                csr_rd_stb_i,
  input  logic [i3c_csr_pkg::csr_addr_w-1:0]  csr_addr_i,
  input  logic [i3c_csr_pkg::csr_data_w-1:0]  csr_wdata_i,
  output logic [i3c_csr_pkg::csr_data_w-1:0]  csr_rdata_o,
  output logic                                csr_rd_valid_o,

  // I3C bus lines
  input  logic                                scl_i,
  input  logic                                sda_i,

  // Configuration outputs
  output logic                                phy_en_o,
  output i3c_bus_pkg::phy_sel_t               phy_mux_select_o,
  output logic                                i2c_active_en_o,
  output logic                                i2c_standby_en_o,
  output logic                                i3c_active_en_o,
  output logic                                i3c_standby_en_o,
  output logic [i3c_bus_pkg::timer_w-1:0]     t_hd_dat_o,
  output logic [i3c_bus_pkg::timer_w-1:0]     t_r_o,
  output logic [i3c_bus_pkg::timer_w-1:0]     t_bus_free_o,
  output logic [i3c_bus_pkg::timer_w-1:0]     t_bus_idle_o,
  output logic [i3c_bus_pkg::timer_w-1:0]     t_bus_available_o,

  // Bus state flags
  output logic                                bus_free_o,
  output logic                                bus_idle_o,
  output logic                                bus_available_o
);
  import i3c_csr_pkg::*;

  hwif_out_t hwif_out;

  csr_bus_if csr_bus ();

  // Host side of the CSR bus from plain pins
  assign csr_bus.wr_stb = csr_wr_stb_i;
  assign csr_bus.rd_stb = csr_rd_stb_i;
  assign csr_bus.addr   = csr_addr_i;
  assign csr_bus.wdata  = csr_wdata_i;
  assign csr_rdata_o    = csr_bus.rdata;
  assign csr_rd_valid_o = csr_bus.rd_valid;

  i3c_csr_regs u_regs (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .bus        (csr_bus.regs),
    .hwif_out_o (hwif_out)
  );

  configuration u_config (
    .hwif_out_i        (hwif_out),
    .phy_en_o          (phy_en_o),
    .phy_mux_select_o  (phy_mux_select_o),
    .i2c_active_en_o   (i2c_active_en_o),
    .i2c_standby_en_o  (i2c_standby_en_o),
    .i3c_active_en_o   (i3c_active_en_o),
    .i3c_standby_en_o  (i3c_standby_en_o),
    .t_hd_dat_o        (t_hd_dat_o),
    .t_r_o             (t_r_o),
    .t_bus_free_o      (t_bus_free_o),
    .t_bus_idle_o      (t_bus_idle_o),
    .t_bus_available_o (t_bus_available_o)
  );

  // Timers run only while the PHY is enabled
  bus_timers u_timers (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .enable_i        (phy_en_o),
    .scl_i           (scl_i),
    .sda_i           (sda_i),
    .t_free_i        (t_bus_free_o),
    .t_idle_i        (t_bus_idle_o),
    .t_aval_i        (t_bus_available_o),
    .bus_free_o      (bus_free_o),
    .bus_idle_o      (bus_idle_o),
    .bus_available_o (bus_available_o)
  );

endmodule

// ==== tb_i3c_cfg.sv ====
// Testbench for the I3C config top that replays CSR ops and bus line steps from the stim file
`timescale 1ns/10ps

module tb_i3c_cfg;
  import i3c_csr_pkg::*;
  import i3c_bus_pkg::*;

  localparam int max_ops = 128;

  logic                  clk;
  logic                  arst_n;
  logic                  csr_wr_stb;
  logic                  csr_rd_stb;
  logic [csr_addr_w-1:0] csr_addr;
  logic [csr_data_w-1:0] csr_wdata;
  logic [csr_data_w-1:0] csr_rdata;
  logic                  csr_rd_valid;
  logic                  scl;
  logic                  sda;
  logic                  phy_en;
  logic [1:0]            phy_mux_select;
  logic                  i2c_active_en;
  logic                  i2c_standby_en;
  logic                  i3c_active_en;
  logic                  i3c_standby_en;
  logic [timer_w-1:0]    t_hd_dat;
  logic [timer_w-1:0]    t_r;
  logic [timer_w-1:0]    t_bus_free;
  logic [timer_w-1:0]    t_bus_idle;
  logic [timer_w-1:0]    t_bus_available;
  logic                  bus_free;
  logic                  bus_idle;
  logic                  bus_available;

  // Loaded stimulus with one opcode and up to five operands per line
  logic [7:0]       op_mem  [max_ops];
  logic [4:0][31:0] arg_mem [max_ops];
  int               n_ops = 0;
  int               cycle_limit = 0;
  int               cycles = 0;
  int               errors = 0;
  int               checks = 0;

  i3c_cfg_top dut (
    .clk_i             (clk),
    .arst_n_i          (arst_n),
    .csr_wr_stb_i      (csr_wr_stb),
    .csr_rd_stb_i      (csr_rd_stb),
    .csr_addr_i        (csr_addr),
    .csr_wdata_i       (csr_wdata),
    .csr_rdata_o       (csr_rdata),
    .csr_rd_valid_o    (csr_rd_valid),
    .scl_i             (scl),
    .sda_i             (sda),
    .phy_en_o          (phy_en),
    .phy_mux_select_o  (phy_mux_select),
    .i2c_active_en_o   (i2c_active_en),
    .i2c_standby_en_o  (i2c_standby_en),
    .i3c_active_en_o   (i3c_active_en),
    .i3c_standby_en_o  (i3c_standby_en),
    .t_hd_dat_o        (t_hd_dat),
    .t_r_o             (t_r),
    .t_bus_free_o      (t_bus_free),
    .t_bus_idle_o      (t_bus_idle),
    .t_bus_available_o (t_bus_available),
    .bus_free_o        (bus_free),
    .bus_idle_o        (bus_idle),
    .bus_available_o   (bus_available)
  );

  // 100 ns clock
  always #50 clk = ~clk;

  // Run limit from the stimulus length
  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Run timed out after %0d cycles without finishing the stimulus", cycles);
      $display("Errors: %0d, checks: %0d", errors + 1, checks);
      $display("tests failed");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      errors++;
    end
  endtask

  // Reads all ops first so the run limit is known before reset
  task automatic load_stim(output bit ok);
    int          fd;
    int          n;
    int          sum_l;
    int          n_other;
    string       line;
    logic [7:0]  op;
    logic [31:0] a0, a1, a2, a3, a4;
    ok = 1'b0;
    sum_l = 0;
    n_other = 0;
    fd = $fopen("i3c_cfg_stim.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd) && n_ops < max_ops) begin
        line = "";
        n = $fgets(line, fd);
        // Skip blank and comment lines
        if (n > 1 && line.getc(0) != "#") begin
          {a0, a1, a2, a3, a4} = '0;
          n = $sscanf(line, "%c %h %h %h %h %h", op, a0, a1, a2, a3, a4);
          op_mem[n_ops]  = op;
          arg_mem[n_ops] = {a4, a3, a2, a1, a0};
          if (op == "L") begin
            sum_l += int'(a2);
          end else begin
            n_other++;
          end
          n_ops++;
        end
      end
      $fclose(fd);
      cycle_limit = 2 * sum_l + 2 * n_other + 50;
      ok = (n_ops > 0);
    end
  endtask

  // Strobe held for exactly one rising edge
  task automatic write_csr(input logic [7:0] addr, input logic [31:0] data);
    csr_addr   = addr;
    csr_wdata  = data;
    csr_wr_stb = 1'b1;
    @(negedge clk);
    csr_wr_stb = 1'b0;
    // A write never gets a read response
    check_value("csr_rd_valid_o after a write", 32'(csr_rd_valid), 32'h0);
  endtask

  // Response due at the edge right after the strobe
  task automatic read_csr(input logic [7:0] addr, input logic [31:0] exp);
    csr_addr   = addr;
    csr_rd_stb = 1'b1;
    @(negedge clk);
    csr_rd_stb = 1'b0;
    check_value("csr_rd_valid_o", 32'(csr_rd_valid), 32'h1);
    check_value($sformatf("read data at 0x%02h", addr), csr_rdata, exp);
  endtask

  task automatic check_mode(input logic [4:0][31:0] a);
    check_value("phy_en_o", 32'(phy_en), a[0]);
    check_value("phy_mux_select_o", 32'(phy_mux_select), a[1]);
    check_value("i3c_active_en_o", 32'(i3c_active_en), a[2]);
    check_value("i3c_standby_en_o", 32'(i3c_standby_en), a[3]);
    // No I2C mode in any code
    check_value("i2c_active_en_o", 32'(i2c_active_en), 32'h0);
    check_value("i2c_standby_en_o", 32'(i2c_standby_en), 32'h0);
  endtask

  task automatic check_timing(input logic [4:0][31:0] a);
    check_value("t_r_o", 32'(t_r), a[0]);
    check_value("t_hd_dat_o", 32'(t_hd_dat), a[1]);
    check_value("t_bus_free_o", 32'(t_bus_free), a[2]);
    check_value("t_bus_idle_o", 32'(t_bus_idle), a[3]);
    check_value("t_bus_available_o", 32'(t_bus_available), a[4]);
  endtask

  task automatic check_flags(input logic [4:0][31:0] a);
    check_value("bus_free_o", 32'(bus_free), a[0]);
    check_value("bus_idle_o", 32'(bus_idle), a[1]);
    check_value("bus_available_o", 32'(bus_available), a[2]);
  endtask

  // Lines held for n rising edges
  task automatic drive_lines(input logic scl_v, input logic sda_v, input int n);
    scl = scl_v;
    sda = sda_v;
    repeat (n) @(negedge clk);
  endtask

  task automatic run_op(input int idx);
    logic [4:0][31:0] a;
    a = arg_mem[idx];
    case (op_mem[idx])
      "W": write_csr(a[0][7:0], a[1]);
      "R": read_csr(a[0][7:0], a[1]);
      "M": check_mode(a);
      "T": check_timing(a);
      "L": drive_lines(a[0][0], a[1][0], int'(a[2]));
      "F": check_flags(a);
      default: begin
        $display("Stimulus op %0d has an unknown opcode '%c'", idx, op_mem[idx]);
        errors++;
      end
    endcase
  endtask

  initial begin
    bit ok;
    clk        = 1'b0;
    arst_n     = 1'b0;
    csr_wr_stb = 1'b0;
    csr_rd_stb = 1'b0;
    csr_addr   = '0;
    csr_wdata  = '0;
    scl        = 1'b0;
    sda        = 1'b0;
    load_stim(ok);
    if (!ok) begin
      errors++;
      $display("Could not open or read any op from i3c_cfg_stim.txt");
      $display("Errors: %0d, checks: %0d", errors, checks);
      $display("tests failed");
      $finish;
    end else begin
      // Reset held over three rising edges and released on a falling edge
      repeat (3) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      check_value("csr_rd_valid_o after reset", 32'(csr_rd_valid), 32'h0);
      for (int i = 0; i < n_ops; i++) begin
        run_op(i);
      end
      $display("Errors: %0d, checks: %0d", errors, checks);
      if (errors == 0) begin
        $display("all tests passed");
      end else begin
        $display("tests failed");
      end
      $finish;
    end
  end

endmodule

// ==== i3c_cfg.f ====
i3c_bus_pkg.sv
i3c_csr_pkg.sv
csr_bus_if.sv
i3c_csr_regs.sv
configuration.sv
bus_timers.sv
i3c_cfg_top.sv
tb_i3c_cfg.sv

// ==== Makefile ====
# Verilator build and run for the I3C config subsystem
# Any variable below can be overridden on the command line
VERILATOR ?= verilator
TOP       ?= tb_i3c_cfg
FILELIST  ?= i3c_cfg.f
STIM      ?= i3c_cfg_stim.txt
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
LOG       ?= sim.log
FAIL_MSG  ?= tests failed
PASS_MSG  ?= all tests passed

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) $(STIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@test -f $(LOG) || { echo "No log file $(LOG), run the simulation first"; exit 1; }
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation ended early"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== i3c_cfg_stim.txt ====
# W addr data | R addr expected | M phy_en sel i3c_act i3c_stby | F free idle aval
# T t_r t_hd_dat t_free t_idle t_aval | L scl sda cycles | all operands hex
R 00 00000000
R 04 00000000
R 08 00000000
R 10 00000000
R 14 00000000
R 18 00000000
R 1C 00000000
R 20 00000000
M 0 0 0 0
T 0 0 0 0 0
F 0 0 0
W 00 FFFFFFFF
R 00 E0000080
W 04 FFFFFFFF
R 04 00000007
W 08 FFFFFFFF
R 08 00000013
M 1 1 1 0
W 0C FFFFFFFF
R 0C 00000000
R 24 00000000
W 08 00000000
M 1 0 0 0
W 08 00000001
M 1 1 1 0
W 08 00000002
M 1 3 0 1
W 00 00000000
M 0 3 0 1
W 10 ABC12345
W 14 00300007
W 18 FFF00005
W 1C 12300008
W 20 0010000C
T 00012345 00000007 00000005 00000008 0000000C
R 10 00012345
W 00 80000000
M 1 3 0 1
L 1 1 5
F 0 0 0
L 1 1 1
F 1 0 0
L 1 1 3
F 1 1 0
L 1 1 3
F 1 1 0
L 1 1 1
F 1 1 1
L 1 0 1
F 0 0 0
L 1 1 6
F 1 0 0
L 0 1 2
F 0 0 0
W 00 00000000
L 1 1 20
F 0 0 0
